// ==== rtl/fetchPkg.sv ====
`default_nettype none

package fetchPkg;

    // Code addresses are halfword aligned, so bit 0 is not stored
    typedef logic [30:0] retAddrT;

    // Fetch block ID, wraps without an ordering bit
    typedef logic [4:0] fetchIdT;

    // Halfword offset inside a fetch block
    typedef logic [2:0] fetchOffT;

    typedef enum logic [1:0] {
        btJump   = 2'd0,
        btCall   = 2'd1,
        btReturn = 2'd2,
        btCond   = 2'd3
    } branchTypeT;

    // Branch predicted for one fetch block
    typedef struct packed {
        logic       valid;
        logic       taken;
        // Only the direction is predicted, target comes later
        logic       dirOnly;
        branchTypeT btype;
        fetchOffT   offs;
        retAddrT    dst;
    } predBranchT;

endpackage

`default_nettype wire

// ==== rtl/rasPkg.sv ====
`default_nettype none

package rasPkg;

    // 16 slots, the index wraps on its own
    typedef logic [3:0] retIdxT;

    // Slot contents overwritten by a speculative push
    typedef struct packed {
        retIdxT             idx;
        fetchPkg::retAddrT  addr;
        fetchPkg::fetchIdT  fetchId;
        fetchPkg::fetchOffT offs;
    } rasSaveT;

    // Write-back of a saved slot during recovery
    typedef struct packed {
        logic              valid;
        retIdxT            idx;
        fetchPkg::retAddrT addr;
    } rasRestoreT;

    // Mispredict position and the stack index to fall back to
    typedef struct packed {
        logic               taken;
        fetchPkg::fetchIdT  fetchId;
        fetchPkg::fetchOffT fetchOffs;
        retIdxT             recoveryIdx;
    } misprT;

endpackage

`default_nettype wire

// ==== rtl/returnStack.sv ====
`timescale 1ns/1ps
`default_nettype none

module returnStack (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 fetchValid,
    input  wire fetchPkg::retAddrT    lastPc,
    input  wire fetchPkg::predBranchT lastBranch,
    input  wire rasPkg::misprT        mispr,
    input  wire rasPkg::rasRestoreT   restore,
    input  wire fetchPkg::fetchIdT    fetchId,
    output fetchPkg::retAddrT         curRetAddr,
    output rasPkg::retIdxT            curIdx,
    output fetchPkg::predBranchT      predBr,
    output rasPkg::rasSaveT           save,
    output logic                      saveValid
);

    localparam int stackSize = 2 ** $bits(rasPkg::retIdxT);

    fetchPkg::retAddrT stack [stackSize];

    rasPkg::retIdxT    idxReg;
    rasPkg::retIdxT    idx;
    rasPkg::retIdxT    baseIdx;
    rasPkg::retIdxT    fwdIdx;
    logic              forwardIdx;
    logic              lastValid;
    logic              push;
    logic              pop;
    fetchPkg::retAddrT addrToPush;
    fetchPkg::retAddrT predAddr;

    // Return address is the halfword after the call
    assign addrToPush = {lastPc[30:$bits(fetchPkg::fetchOffT)], lastBranch.offs} + 31'd1;

    assign push = lastValid && lastBranch.valid && lastBranch.btype == fetchPkg::btCall
        && !mispr.taken;
    assign pop = lastValid && lastBranch.valid && lastBranch.btype == fetchPkg::btReturn
        && !mispr.taken;

    // The index register misses the mispredict cycle, so the recovered index
    // is forwarded for one more cycle
    always_comb begin
        baseIdx = forwardIdx ? fwdIdx : idxReg;
        if (mispr.taken) begin
            idx = mispr.recoveryIdx;
        end else if (push) begin
            idx = baseIdx + 4'd1;
        end else if (pop) begin
            idx = baseIdx - 4'd1;
        end else begin
            idx = baseIdx;
        end
    end

    // A call in the previous block has not reached the stack yet
    assign predAddr = push ? addrToPush : stack[idx];

    // Old slot contents go to the recovery queue
    always_comb begin
        save.idx     = idx;
        save.addr    = stack[idx];
        save.fetchId = fetchId;
        save.offs    = lastBranch.offs;
        saveValid    = push;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            idxReg     <= '0;
            forwardIdx <= 1'b0;
            lastValid  <= 1'b0;
        end else begin
            forwardIdx <= mispr.taken;
            lastValid  <= fetchValid && !mispr.taken;
            if (!mispr.taken) begin
                idxReg <= idx;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mispr.taken) begin
            fwdIdx <= mispr.recoveryIdx;
        end
    end

    always_ff @(posedge clk) begin
        if (restore.valid) begin
            stack[restore.idx] <= restore.addr;
        end
        if (push) begin
            stack[idx] <= addrToPush;
        end
    end

    // Prediction registered on each fetch strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            curIdx       <= '0;
            predBr.valid <= 1'b0;
        end else if (fetchValid) begin
            curIdx         <= idx;
            curRetAddr     <= predAddr;
            predBr.valid   <= 1'b1;
            predBr.taken   <= 1'b1;
            predBr.dirOnly <= 1'b0;
            predBr.btype   <= fetchPkg::btReturn;
            predBr.offs    <= '0;
            predBr.dst     <= predAddr;
        end
    end

    // Restores only run while fetch is stalled
    restoreNoPush: assert property (@(posedge clk) disable iff (rst)
        restore.valid |-> !push)
        else $error("Restore write collides with a speculative push");

endmodule

`default_nettype wire

// ==== rtl/recoveryQueue.sv ====
`timescale 1ns/1ps
`default_nettype none

module recoveryQueue #(
    parameter int queueDepth = 4
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire rasPkg::rasSaveT   save,
    input  wire logic              saveValid,
    input  wire rasPkg::misprT     mispr,
    input  wire fetchPkg::fetchIdT commitFetchId,
    output rasPkg::rasRestoreT     restore,
    output logic                   stall
);

    localparam int ptrWidth = $clog2(queueDepth);

    typedef logic [ptrWidth-1:0] ptrT;

    rasPkg::rasSaveT mem [queueDepth];

    // Head is the next free slot, tail the oldest entry
    ptrT head;
    ptrT tail;
    ptrT top;
    logic empty;
    logic full;
    logic saveAccept;
    logic recovering;
    logic younger;
    logic comChanged;
    logic retire;

    fetchPkg::fetchIdT  recId;
    fetchPkg::fetchIdT  recBase;
    fetchPkg::fetchOffT recOffs;
    fetchPkg::fetchIdT  lastComId;
    fetchPkg::fetchIdT  topDist;
    fetchPkg::fetchIdT  recDist;
    fetchPkg::fetchIdT  tailDist;
    fetchPkg::fetchIdT  comDist;
    rasPkg::rasSaveT    topEntry;
    rasPkg::rasSaveT    tailEntry;

    assign top        = ptrT'(head - 1'b1);
    assign empty      = head == tail;
    assign full       = ptrT'(head + 1'b1) == tail;
    assign saveAccept = saveValid && !full;
    assign topEntry   = mem[top];
    assign tailEntry  = mem[tail];

    // IDs wrap, so order is judged by distance from the last commit ID
    always_comb begin
        topDist  = topEntry.fetchId - recBase;
        recDist  = recId - recBase;
        tailDist = tailEntry.fetchId - lastComId;
        comDist  = commitFetchId - lastComId;
    end

    // Same block: the later offset is younger
    assign younger = (topDist > recDist) || (topDist == recDist && topEntry.offs > recOffs);

    always_comb begin
        restore.valid = recovering && !empty && younger;
        restore.idx   = topEntry.idx;
        restore.addr  = topEntry.addr;
    end

    assign comChanged = !recovering && !mispr.taken && lastComId != commitFetchId;
    assign retire     = comChanged && !empty && tailDist < comDist;
    assign stall      = recovering;

    always_ff @(posedge clk) begin
        if (rst) begin
            head       <= '0;
            tail       <= '0;
            recovering <= 1'b0;
            lastComId  <= '0;
        end else begin
            if (mispr.taken) begin
                recovering <= !empty;
            end else if (recovering && !restore.valid) begin
                recovering <= 1'b0;
            end

            // Restores pop from the head, newest first
            if (restore.valid) begin
                head <= top;
            end else if (saveAccept) begin
                head <= ptrT'(head + 1'b1);
            end

            if (retire) begin
                tail      <= ptrT'(tail + 1'b1);
                lastComId <= tailEntry.fetchId;
            end else if (comChanged) begin
                lastComId <= commitFetchId;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (saveAccept) begin
            mem[head] <= save;
        end
        if (mispr.taken) begin
            recId   <= mispr.fetchId;
            recOffs <= mispr.fetchOffs;
            recBase <= lastComId;
        end
    end

    saveKeepsOrder: assert property (@(posedge clk) disable iff (rst)
        saveAccept |=> head != tail)
        else $error("Queue head wrapped onto the tail after a save");

    // Each stored entry is written back at most once, then the empty queue ends recovery
    emptyNoRestore: assert property (@(posedge clk) disable iff (rst || mispr.taken)
        $rose(stall) |-> ##queueDepth !stall)
        else $error("Recovery kept running past an empty queue");

endmodule

`default_nettype wire

// ==== rtl/returnPredictor.sv ====
`timescale 1ns/1ps
`default_nettype none

module returnPredictor #(
    parameter int queueDepth = 4
) (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 fetchValid,
    input  wire fetchPkg::fetchIdT    fetchId,
    input  wire fetchPkg::retAddrT    lastPc,
    input  wire fetchPkg::predBranchT lastBranch,
    input  wire rasPkg::misprT        mispr,
    input  wire fetchPkg::fetchIdT    commitFetchId,
    output fetchPkg::retAddrT         curRetAddr,
    output rasPkg::retIdxT            curIdx,
    output fetchPkg::predBranchT      predBr,
    output logic                      stall
);

    rasPkg::rasSaveT    save;
    logic               saveValid;
    rasPkg::rasRestoreT restore;

    returnStack i_stack (
        .clk        (clk),
        .rst        (rst),
        .fetchValid (fetchValid),
        .lastPc     (lastPc),
        .lastBranch (lastBranch),
        .mispr      (mispr),
        .restore    (restore),
        .fetchId    (fetchId),
        .curRetAddr (curRetAddr),
        .curIdx     (curIdx),
        .predBr     (predBr),
        .save       (save),
        .saveValid  (saveValid)
    );

    recoveryQueue #(
        .queueDepth (queueDepth)
    ) i_queue (
        .clk           (clk),
        .rst           (rst),
        .save          (save),
        .saveValid     (saveValid),
        .mispr         (mispr),
        .commitFetchId (commitFetchId),
        .restore       (restore),
        .stall         (stall)
    );

endmodule

`default_nettype wire

// ==== tests/returnPredictorTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module returnPredictorTb;

    localparam int queueDepth = 4;
    // Rough sum of all test sequences, reset included
    localparam int testCycles = 70;
    localparam int cycleLimit = 2 * testCycles + 100;

    typedef struct packed {
        rasPkg::rasSaveT save;
        logic            known;
    } entryT;

    logic                 clk;
    logic                 rst;
    logic                 fetchValid;
    fetchPkg::fetchIdT    fetchId;
    fetchPkg::retAddrT    lastPc;
    fetchPkg::predBranchT lastBranch;
    rasPkg::misprT        mispr;
    fetchPkg::fetchIdT    commitFetchId;
    fetchPkg::retAddrT    curRetAddr;
    rasPkg::retIdxT       curIdx;
    fetchPkg::predBranchT predBr;
    logic                 stall;

    // Reference model state, slots never written are not checked
    fetchPkg::retAddrT mStack [16];
    logic              mKnown [16];
    rasPkg::retIdxT    mIdx;
    logic              mLastFetch;
    fetchPkg::fetchIdT mComBase;
    entryT             mQueue [$];
    fetchPkg::retAddrT expAddr;
    rasPkg::retIdxT    expIdx;
    logic              expKnown;
    logic              expStall;

    logic [31:0]       lfsr;
    fetchPkg::fetchIdT nextId;
    int                errors = 0;
    int                cycles = 0;

    returnPredictor #(.queueDepth(queueDepth)) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Younger when further from the commit base, or later in the same block
    function automatic logic isYounger(input entryT e, input rasPkg::misprT m,
            input fetchPkg::fetchIdT base);
        fetchPkg::fetchIdT eDist;
        fetchPkg::fetchIdT mDist;
        eDist = e.save.fetchId - base;
        mDist = m.fetchId - base;
        return eDist > mDist || (eDist == mDist && e.save.offs > m.fetchOffs);
    endfunction

    task automatic randBits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrNext(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // One fetch block, carrying the branch predicted in the block before
    task automatic fetchCycle(input logic brValid, input fetchPkg::branchTypeT kind);
        logic [31:0] r;
        @(negedge clk);
        fetchValid = 1'b1;
        fetchId = nextId;
        nextId = nextId + 5'd1;
        randBits(31, r);
        lastPc = r[30:0];
        randBits(3, r);
        lastBranch = '0;
        lastBranch.valid = brValid;
        lastBranch.taken = brValid;
        lastBranch.btype = kind;
        lastBranch.offs = r[2:0];
    endtask

    task automatic idleCycle();
        @(negedge clk);
        fetchValid = 1'b0;
        lastBranch = '0;
        mispr = '0;
    endtask

    task automatic mispredict(input fetchPkg::fetchIdT id, input fetchPkg::fetchOffT offs,
            input rasPkg::retIdxT recIdx);
        idleCycle();
        mispr.taken = 1'b1;
        mispr.fetchId = id;
        mispr.fetchOffs = offs;
        mispr.recoveryIdx = recIdx;
        idleCycle();
        // Fetch holds off until recovery is over
        while (stall) begin
            @(negedge clk);
        end
    endtask

    // Retirement takes one cycle per entry
    task automatic advanceCommit(input fetchPkg::fetchIdT id);
        idleCycle();
        commitFetchId = id;
        repeat (queueDepth + 1) idleCycle();
    endtask

    always @(posedge clk) begin
        logic              doPush;
        logic              doPop;
        fetchPkg::retAddrT pushAddr;
        fetchPkg::fetchIdT comDist;
        entryT             e;
        if (rst) begin
            mIdx = '0;
            mLastFetch = 1'b0;
            mComBase = '0;
            expStall = 1'b0;
            mQueue.delete();
            for (int i = 0; i < 16; i++) begin
                mKnown[i] = 1'b0;
            end
        end else begin
            doPush = mLastFetch && lastBranch.valid && lastBranch.btype == fetchPkg::btCall
                && !mispr.taken;
            doPop = mLastFetch && lastBranch.valid && lastBranch.btype == fetchPkg::btReturn
                && !mispr.taken;
            // Halfword after the call
            pushAddr = {lastPc[30:3], lastBranch.offs} + 31'd1;
            if (mispr.taken) begin
                expStall = mQueue.size() != 0;
                mIdx = mispr.recoveryIdx;
                while (mQueue.size() != 0 && isYounger(mQueue[$], mispr, mComBase)) begin
                    e = mQueue.pop_back();
                    mStack[e.save.idx] = e.save.addr;
                    mKnown[e.save.idx] = e.known;
                end
            end else if (doPush) begin
                mIdx = mIdx + 4'd1;
                e.save.idx = mIdx;
                e.save.addr = mStack[mIdx];
                e.save.fetchId = fetchId;
                e.save.offs = lastBranch.offs;
                e.known = mKnown[mIdx];
                // A full queue drops the save
                if (mQueue.size() < queueDepth - 1) begin
                    mQueue.push_back(e);
                end
                mStack[mIdx] = pushAddr;
                mKnown[mIdx] = 1'b1;
            end else if (doPop) begin
                mIdx = mIdx - 4'd1;
            end
            if (!mispr.taken && commitFetchId != mComBase) begin
                comDist = commitFetchId - mComBase;
                while (mQueue.size() != 0
                        && fetchPkg::fetchIdT'(mQueue[0].save.fetchId - mComBase) < comDist) begin
                    void'(mQueue.pop_front());
                end
                mComBase = commitFetchId;
            end
            if (fetchValid) begin
                expIdx = mIdx;
                expAddr = mStack[mIdx];
                expKnown = mKnown[mIdx];
            end
            mLastFetch = fetchValid;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycleLimit) begin
            $display("Run stopped after %0d cycles, stall never fell, errors: %0d",
                cycles, errors);
            $display("Simulation failed");
            $finish;
        end
    end

    resetValues: assert property (@(posedge clk) $fell(rst) |-> !stall && !predBr.valid)
        else begin
            errors++;
            $display("stall or predBr.valid is high right after reset");
        end

    retAddrMatch: assert property (@(posedge clk) disable iff (rst)
        fetchValid |=> !expKnown || curRetAddr == expAddr)
        else begin
            errors++;
            $display("** Error curRetAddr expected %h got %h",
                $sampled(expAddr), $sampled(curRetAddr));
        end

    dstMatch: assert property (@(posedge clk) disable iff (rst)
        fetchValid |=> !expKnown || predBr.dst == expAddr)
        else begin
            errors++;
            $display("** Error predBr.dst expected %h got %h",
                $sampled(expAddr), $sampled(predBr.dst));
        end

    idxMatch: assert property (@(posedge clk) disable iff (rst)
        fetchValid |=> curIdx == expIdx)
        else begin
            errors++;
            $display("** Error curIdx expected %h got %h", $sampled(expIdx), $sampled(curIdx));
        end

    // The return target comes with the prediction, so it is never direction-only
    predKind: assert property (@(posedge clk) disable iff (rst)
        fetchValid |=> predBr.valid && predBr.taken && !predBr.dirOnly
            && predBr.btype == fetchPkg::btReturn)
        else begin
            errors++;
            $display("Prediction after a fetch strobe is not a valid taken return");
        end

    stallRise: assert property (@(posedge clk) disable iff (rst)
        mispr.taken |=> stall == expStall)
        else begin
            errors++;
            $display("** Error stall expected %h got %h", $sampled(expStall), $sampled(stall));
        end

    initial begin
        fetchPkg::fetchIdT callId;
        rasPkg::retIdxT    baseIdx;
        rst = 1'b1;
        fetchValid = 1'b0;
        fetchId = '0;
        lastPc = '0;
        lastBranch = '0;
        mispr = '0;
        commitFetchId = '0;
        lfsr = 32'd84891;
        nextId = '0;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        // First prediction after reset
        fetchCycle(1'b0, fetchPkg::btJump);
        idleCycle();

        // Each call is forwarded into its own prediction, returns come back LIFO
        fetchCycle(1'b0, fetchPkg::btJump);
        repeat (6) fetchCycle(1'b1, fetchPkg::btCall);
        repeat (6) fetchCycle(1'b1, fetchPkg::btReturn);
        advanceCommit(nextId);

        // Committed calls leave nothing to restore
        fetchCycle(1'b0, fetchPkg::btJump);
        fetchCycle(1'b1, fetchPkg::btCall);
        callId = fetchId;
        repeat (2) fetchCycle(1'b1, fetchPkg::btCall);
        fetchCycle(1'b0, fetchPkg::btJump);
        advanceCommit(nextId);
        mispredict(callId, 3'd0, mIdx);
        fetchCycle(1'b0, fetchPkg::btJump);
        repeat (3) fetchCycle(1'b1, fetchPkg::btReturn);

        // Younger saves go back, the first call of the same block stays
        baseIdx = mIdx;
        fetchCycle(1'b0, fetchPkg::btJump);
        fetchCycle(1'b1, fetchPkg::btCall);
        callId = fetchId;
        repeat (2) fetchCycle(1'b1, fetchPkg::btCall);
        fetchCycle(1'b0, fetchPkg::btJump);
        mispredict(callId, 3'd7, baseIdx + 4'd3);
        fetchCycle(1'b0, fetchPkg::btJump);
        repeat (3) fetchCycle(1'b1, fetchPkg::btReturn);
        idleCycle();
        idleCycle();

        $display("Checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== returnPredictor.f ====
rtl/fetchPkg.sv
rtl/rasPkg.sv
rtl/returnStack.sv
rtl/recoveryQueue.sv
rtl/returnPredictor.sv
tests/returnPredictorTb.sv

// ==== Makefile ====
TOP = returnPredictorTb

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation, log in sim.log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f returnPredictor.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Simulation failed" sim.log; then exit 1; fi
	@grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: help test clean
